// ==== csrPkg.sv ====
package csrPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [11:0] {
        csrMstatus       = 12'h300,
        csrMisa          = 12'h301,
        csrMie           = 12'h304,
        csrMtvec         = 12'h305,
        csrMcounteren    = 12'h306,
        csrMcountinhibit = 12'h320,
        csrMscratch      = 12'h340,
        csrMepc          = 12'h341,
        csrMcause        = 12'h342,
        csrMtval         = 12'h343,
        csrMip           = 12'h344,
        csrMcycle        = 12'hB00,
        csrMinstret      = 12'hB02,
        csrMcycleh       = 12'hB80,
        csrMinstreth     = 12'hB82,
        csrCycle         = 12'hC00,  // user aliases, gated by mcounteren
        csrInstret       = 12'hC02,
        csrCycleh        = 12'hC80,
        csrInstreth      = 12'hC82,
        csrMvendorid     = 12'hF11,
        csrMarchid       = 12'hF12,
        csrMimpid        = 12'hF13,
        csrMhartid       = 12'hF14
    } csrAddr_t;

    typedef enum logic [2:0] {
        opRead         = 3'd0,
        opReadWrite    = 3'd1,
        opReadSet      = 3'd2,
        opReadClear    = 3'd3,
        opReadWriteImm = 3'd4,
        opReadSetImm   = 3'd5,
        opReadClearImm = 3'd6,
        opMret         = 3'd7
    } csrOp_t;

    typedef enum logic [1:0] {
        flagsNone     = 2'd0,
        flagsOrdering = 2'd1,  // pipeline must drain after a CSR write
        flagsIllegal  = 2'd2,
        flagsXret     = 2'd3
    } resFlags_t;

    typedef enum logic [1:0] {
        privUser    = 2'd0,
        privMachine = 2'd3
    } priv_t;

    // mip / mie bit positions
    localparam int irqMSI = 3;
    localparam int irqMTI = 7;
    localparam int irqMEI = 11;

    // RV32 I M U
    localparam word_t MISA_VALUE    = 32'h4010_1100;
    localparam word_t MARCHID_VALUE = 32'h0000_002A;
    localparam word_t MIMPID_VALUE  = 32'h0001_0003;

    // mcounteren / mcountinhibit bits
    localparam int cntCycle   = 0;
    localparam int cntInstret = 2;

endpackage

// ==== csrReadMux.sv ====
`timescale 1ns/1ps

module csrReadMux import csrPkg::*; (
    input  csrAddr_t    addr,
    input  priv_t       priv,
    input  word_t       mstatus,
    input  word_t       mtvec,
    input  word_t       mepc,
    input  word_t       mcause,
    input  word_t       mtval,
    input  word_t       mie,
    input  word_t       mip,
    input  word_t       mscratch,
    input  logic [63:0] mcycle,
    input  logic [63:0] minstret,
    input  logic [2:0]  mcounteren,
    input  logic [2:0]  mcountinhibit,
    output word_t       rdata,
    output logic        csrExists
);

    logic cycleOk;
    logic instretOk;

    // machine mode always sees the counters
    assign cycleOk = (priv == privMachine) || mcounteren[cntCycle];
    assign instretOk = (priv == privMachine) || mcounteren[cntInstret];

    always_comb begin
        rdata = '0;
        csrExists = 1'b1;
        case (addr)
            csrMstatus:       rdata = mstatus;
            csrMisa:          rdata = MISA_VALUE;
            csrMie:           rdata = mie;
            csrMtvec:         rdata = mtvec;
            csrMcounteren:    rdata = word_t'(mcounteren);
            csrMcountinhibit: rdata = word_t'(mcountinhibit);
            csrMscratch:      rdata = mscratch;
            csrMepc:          rdata = mepc;
            csrMcause:        rdata = mcause;
            csrMtval:         rdata = mtval;
            csrMip:           rdata = mip;
            csrMcycle:        rdata = mcycle[31:0];
            csrMcycleh:       rdata = mcycle[63:32];
            csrMinstret:      rdata = minstret[31:0];
            csrMinstreth:     rdata = minstret[63:32];
            csrCycle: begin
                rdata = mcycle[31:0];
                csrExists = cycleOk;
            end
            csrCycleh: begin
                rdata = mcycle[63:32];
                csrExists = cycleOk;
            end
            csrInstret: begin
                rdata = minstret[31:0];
                csrExists = instretOk;
            end
            csrInstreth: begin
                rdata = minstret[63:32];
                csrExists = instretOk;
            end
            csrMarchid:       rdata = MARCHID_VALUE;
            csrMimpid:        rdata = MIMPID_VALUE;
            csrMvendorid,
            csrMhartid:       rdata = '0;  // non-commercial, single hart
            default:          csrExists = 1'b0;
        endcase
    end

endmodule

// ==== csrExecute.sv ====
`timescale 1ns/1ps

module csrExecute import csrPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       uopValid,
    input  csrOp_t     uopOp,
    input  csrAddr_t   uopAddr,
    input  word_t      uopSrc,
    input  logic [4:0] uopZimm,
    input  word_t      rdata,
    input  logic       csrExists,
    input  priv_t      priv,
    output logic       wrEn,
    output csrAddr_t   wrAddr,
    output word_t      wrData,
    output logic       mretEn,
    output logic       resValid,
    output word_t      resData,
    output resFlags_t  resFlags
);

    logic  isMret;
    logic  isImm;
    logic  doesWrite;
    logic  illegal;
    word_t src;

    assign isMret = (uopOp == opMret);
    assign isImm = (uopOp == opReadWriteImm) || (uopOp == opReadSetImm)
                || (uopOp == opReadClearImm);
    assign doesWrite = (uopOp != opRead) && !isMret;
    assign src = isImm ? word_t'(uopZimm) : uopSrc;  // zimm is zero extended

    always_comb begin
        if (isMret) begin
            illegal = (priv != privMachine);
        end else begin
            // addr[9:8] is the lowest privilege allowed, addr[11:10] == 3 is read-only
            illegal = (uopAddr[9:8] > priv) || !csrExists
                   || (doesWrite && uopAddr[11:10] == 2'b11);
        end
    end

    always_comb begin
        case (uopOp)
            opReadSet,
            opReadSetImm:   wrData = rdata | src;
            opReadClear,
            opReadClearImm: wrData = rdata & ~src;
            default:        wrData = src;
        endcase
    end

    // state is written at the accepting edge, so a back-to-back read sees it
    assign wrEn = uopValid && doesWrite && !illegal;
    assign wrAddr = uopAddr;
    assign mretEn = uopValid && isMret && !illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= uopValid;
        end
    end

    always_ff @(posedge clk) begin
        if (uopValid) begin
            resData <= (illegal || isMret) ? '0 : rdata;  // old value
            if (illegal) begin
                resFlags <= flagsIllegal;
            end else if (isMret) begin
                resFlags <= flagsXret;
            end else if (doesWrite) begin
                resFlags <= flagsOrdering;
            end else begin
                resFlags <= flagsNone;
            end
        end
    end

endmodule

// ==== trapState.sv ====
`timescale 1ns/1ps

module trapState import csrPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wrEn,
    input  csrAddr_t   wrAddr,
    input  word_t      wrData,
    input  logic       mretEn,
    input  logic       trapValid,
    input  logic       trapIsInterrupt,
    input  logic [3:0] trapCause,
    input  word_t      trapPc,
    input  word_t      trapTval,
    input  logic       swIrq,
    input  logic       timerIrq,
    input  logic       extIrq,
    output priv_t      priv,
    output word_t      mstatus,
    output word_t      mtvec,
    output word_t      mepc,
    output word_t      mcause,
    output word_t      mtval,
    output word_t      mie,
    output word_t      mip,
    output word_t      mscratch,
    output word_t      trapVector,
    output word_t      retVector,
    output logic       irqPending,
    output logic [3:0] irqCause
);

    localparam word_t irqMask = (word_t'(1) << irqMSI) | (word_t'(1) << irqMTI)
                              | (word_t'(1) << irqMEI);

    logic  statusMie;
    logic  statusMpie;
    priv_t statusMpp;
    word_t irqActive;

    // only mie (3), mpie (7) and mpp (12:11) are implemented
    assign mstatus = {19'b0, statusMpp, 3'b0, statusMpie, 3'b0, statusMie, 3'b0};
    assign trapVector = mtvec;  // direct mode only

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= privMachine;
            statusMie <= 1'b0;
            statusMpie <= 1'b0;
            statusMpp <= privUser;
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
            mie <= '0;
            mip <= '0;
            mscratch <= '0;
            retVector <= '0;
        end else begin
            mip <= '0;
            mip[irqMSI] <= swIrq;
            mip[irqMTI] <= timerIrq;
            mip[irqMEI] <= extIrq;

            if (wrEn) begin
                case (wrAddr)
                    csrMstatus: begin
                        statusMie <= wrData[3];
                        statusMpie <= wrData[7];
                        // mpp only holds user or machine
                        statusMpp <= (wrData[12:11] == 2'b11) ? privMachine : privUser;
                    end
                    csrMie:      mie <= wrData & irqMask;
                    csrMtvec:    mtvec <= {wrData[31:2], 2'b00};
                    csrMepc:     mepc <= {wrData[31:1], 1'b0};
                    csrMcause:   mcause <= wrData;
                    csrMtval:    mtval <= wrData;
                    csrMscratch: mscratch <= wrData;
                    default: ;
                endcase
            end

            if (mretEn) begin
                statusMie <= statusMpie;
                priv <= statusMpp;
                statusMpp <= privUser;
                retVector <= mepc;
            end

            // trap entry last, so it wins over a CSR write on the same edge
            if (trapValid) begin
                statusMpie <= statusMie;
                statusMie <= 1'b0;
                statusMpp <= priv;
                mepc <= {trapPc[31:1], 1'b0};
                mcause <= {trapIsInterrupt, 27'b0, trapCause};
                mtval <= trapTval;
                priv <= privMachine;
            end
        end
    end

    assign irqActive = mie & mip;
    assign irqPending = ((priv == privUser) || statusMie) && (|irqActive);

    always_comb begin
        if (irqActive[irqMEI]) begin
            irqCause = 4'(irqMEI);
        end else if (irqActive[irqMSI]) begin
            irqCause = 4'(irqMSI);
        end else if (irqActive[irqMTI]) begin
            irqCause = 4'(irqMTI);
        end else begin
            irqCause = 4'd0;
        end
    end

endmodule

// ==== perfCounters.sv ====
`timescale 1ns/1ps

module perfCounters import csrPkg::*; #(
    parameter int NUM_COMMIT = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NUM_COMMIT-1:0] commitValid,
    input  logic                  wrEn,
    input  csrAddr_t              wrAddr,
    input  word_t                 wrData,
    output logic [63:0]           mcycle,
    output logic [63:0]           minstret,
    output logic [2:0]            mcounteren,
    output logic [2:0]            mcountinhibit
);

    // no time counter, so only cycle and instret bits are kept
    localparam logic [2:0] cntMask = 3'((1 << cntCycle) | (1 << cntInstret));

    logic [$clog2(NUM_COMMIT+1)-1:0] retired;
    logic [63:0] cycleNext;
    logic [63:0] instretNext;

    always_comb begin
        retired = '0;
        for (int i = 0; i < NUM_COMMIT; i++) begin
            retired = retired + commitValid[i];
        end
    end

    assign cycleNext = mcountinhibit[cntCycle] ? mcycle : mcycle + 64'd1;
    assign instretNext = mcountinhibit[cntInstret] ? minstret : minstret + 64'(retired);

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
            mcounteren <= '0;
            mcountinhibit <= '0;
        end else begin
            mcycle <= cycleNext;
            minstret <= instretNext;
            if (wrEn) begin
                case (wrAddr)  // a write drops that counter's increment
                    csrMcycle:        mcycle <= {mcycle[63:32], wrData};
                    csrMcycleh:       mcycle <= {wrData, mcycle[31:0]};
                    csrMinstret:      minstret <= {minstret[63:32], wrData};
                    csrMinstreth:     minstret <= {wrData, minstret[31:0]};
                    csrMcounteren:    mcounteren <= wrData[2:0] & cntMask;
                    csrMcountinhibit: mcountinhibit <= wrData[2:0] & cntMask;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== csrUnit.sv ====
`timescale 1ns/1ps

module csrUnit import csrPkg::*; #(
    parameter int NUM_COMMIT = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  uopValid,
    input  csrOp_t                uopOp,
    input  csrAddr_t              uopAddr,
    input  word_t                 uopSrc,
    input  logic [4:0]            uopZimm,
    input  logic                  trapValid,
    input  logic                  trapIsInterrupt,
    input  logic [3:0]            trapCause,
    input  word_t                 trapPc,
    input  word_t                 trapTval,
    input  logic [NUM_COMMIT-1:0] commitValid,
    input  logic                  swIrq,
    input  logic                  timerIrq,
    input  logic                  extIrq,
    output logic                  resValid,
    output word_t                 resData,
    output resFlags_t             resFlags,
    output priv_t                 priv,
    output word_t                 trapVector,
    output word_t                 retVector,
    output logic                  irqPending,
    output logic [3:0]            irqCause
);

    logic        wrEn;
    csrAddr_t    wrAddr;
    word_t       wrData;
    logic        mretEn;
    word_t       rdata;
    logic        csrExists;
    word_t       mstatus, mtvec, mepc, mcause, mtval, mie, mip, mscratch;
    logic [63:0] mcycle, minstret;
    logic [2:0]  mcounteren, mcountinhibit;

    csrExecute execute (
        .clk, .rst, .uopValid, .uopOp, .uopAddr, .uopSrc, .uopZimm,
        .rdata, .csrExists, .priv,
        .wrEn, .wrAddr, .wrData, .mretEn, .resValid, .resData, .resFlags
    );

    csrReadMux readMux (
        .addr(uopAddr), .priv, .mstatus, .mtvec, .mepc, .mcause, .mtval,
        .mie, .mip, .mscratch, .mcycle, .minstret, .mcounteren, .mcountinhibit,
        .rdata, .csrExists
    );

    trapState trap (
        .clk, .rst, .wrEn, .wrAddr, .wrData, .mretEn,
        .trapValid, .trapIsInterrupt, .trapCause, .trapPc, .trapTval,
        .swIrq, .timerIrq, .extIrq,
        .priv, .mstatus, .mtvec, .mepc, .mcause, .mtval, .mie, .mip, .mscratch,
        .trapVector, .retVector, .irqPending, .irqCause
    );

    perfCounters #(.NUM_COMMIT(NUM_COMMIT)) counters (
        .clk, .rst, .commitValid, .wrEn, .wrAddr, .wrData,
        .mcycle, .minstret, .mcounteren, .mcountinhibit
    );

endmodule

// ==== tbCsrUnit.sv ====
`timescale 1ns/1ps

module tbCsrUnit import csrPkg::*; ();

    typedef struct packed {
        logic [2:0] group;
        logic       valid;
        csrOp_t     op;
        csrAddr_t   addr;
        word_t      src;
        logic [4:0] zimm;
        logic       trapValid;
        logic       trapIsInt;
        logic [3:0] trapCause;
        word_t      trapPc;
        word_t      trapTval;
        logic [2:0] irq;  // {ext, timer, sw}
        logic [3:0] commit;
        resFlags_t  expFlags;
        word_t      expData;
        priv_t      expPriv;
        logic       expPend;
        logic [3:0] expCause;
        word_t      expRet;
        word_t      expVec;
    } row_t;

    logic clk = 1'b0;
    logic rst;
    logic uopValid;
    csrOp_t uopOp;
    csrAddr_t uopAddr;
    word_t uopSrc;
    logic [4:0] uopZimm;
    logic trapValid;
    logic trapIsInterrupt;
    logic [3:0] trapCause;
    word_t trapPc;
    word_t trapTval;
    logic [3:0] commitValid;
    logic swIrq;
    logic timerIrq;
    logic extIrq;
    logic resValid;
    word_t resData;
    resFlags_t resFlags;
    priv_t priv;
    word_t trapVector;
    word_t retVector;
    logic irqPending;
    logic [3:0] irqCause;

    row_t rows [0:63];
    int nRows = 0;
    int errors = 0;
    int checks = 0;
    int groupErrors = 0;
    int cycles = 0;
    int cycleLimit = 1000;
    logic [31:0] seed = 32'hcfe17af2;
    string groupName [1:6];

    // reference model state
    priv_t mPriv;
    logic mStMie, mStMpie;
    priv_t mStMpp;
    word_t mMtvec, mMepc, mMcause, mMtval, mMie, mMip, mMscratch, mRet;
    logic [63:0] mCycle, mInstret;
    logic [2:0] mCntEn, mInhibit;

    csrUnit #(.NUM_COMMIT(4)) dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("run stopped: cycle limit of %0d reached", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic word_t nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            groupErrors++;
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic addRow(input logic [2:0] grp, input logic v, input csrOp_t op,
                          input csrAddr_t a, input word_t src, input logic [4:0] zimm);
        row_t r;
        r = '0;
        r.group = grp;
        r.valid = v;
        r.op = op;
        r.addr = a;
        r.src = src;
        r.zimm = zimm;
        rows[nRows] = r;
        nRows++;
    endtask

    // these modify the most recent row
    task automatic setTrap(input logic isInt, input logic [3:0] cause, input word_t pc,
                           input word_t tval);
        rows[nRows-1].trapValid = 1'b1;
        rows[nRows-1].trapIsInt = isInt;
        rows[nRows-1].trapCause = cause;
        rows[nRows-1].trapPc = pc;
        rows[nRows-1].trapTval = tval;
    endtask

    task automatic setIrq(input logic [2:0] lines);
        rows[nRows-1].irq = lines;
    endtask

    task automatic setCommit(input logic [3:0] c);
        rows[nRows-1].commit = c;
    endtask

    function automatic logic [32:0] modelRead(input logic [11:0] a);
        word_t st;
        st = (word_t'(mStMie) << 3) | (word_t'(mStMpie) << 7) | (word_t'(mStMpp) << 11);
        case (a)
            12'h300: return {1'b1, st};
            12'h301: return {1'b1, MISA_VALUE};
            12'h304: return {1'b1, mMie};
            12'h305: return {1'b1, mMtvec};
            12'h306: return {1'b1, 29'b0, mCntEn};
            12'h320: return {1'b1, 29'b0, mInhibit};
            12'h340: return {1'b1, mMscratch};
            12'h341: return {1'b1, mMepc};
            12'h342: return {1'b1, mMcause};
            12'h343: return {1'b1, mMtval};
            12'h344: return {1'b1, mMip};
            12'hB00: return {1'b1, mCycle[31:0]};
            12'hB80: return {1'b1, mCycle[63:32]};
            12'hB02: return {1'b1, mInstret[31:0]};
            12'hB82: return {1'b1, mInstret[63:32]};
            12'hC00: return {mPriv == privMachine || mCntEn[0], mCycle[31:0]};
            12'hC80: return {mPriv == privMachine || mCntEn[0], mCycle[63:32]};
            12'hC02: return {mPriv == privMachine || mCntEn[2], mInstret[31:0]};
            12'hC82: return {mPriv == privMachine || mCntEn[2], mInstret[63:32]};
            12'hF11, 12'hF14: return {1'b1, 32'h0};
            12'hF12: return {1'b1, MARCHID_VALUE};
            12'hF13: return {1'b1, MIMPID_VALUE};
            default: return {1'b0, 32'h0};
        endcase
    endfunction

    // fills in the expected fields of row i and advances the model by one edge
    task automatic modelStep(input int i);
        row_t r;
        logic [32:0] rd;
        logic isImm, isMret, doesWrite, illegal, doWr;
        word_t src, wdata;
        logic oldMie;
        priv_t oldPriv;
        int pop;
        r = rows[i];
        rd = modelRead(r.addr);
        isMret = r.op == opMret;
        isImm = r.op inside {opReadWriteImm, opReadSetImm, opReadClearImm};
        doesWrite = r.op != opRead && !isMret;
        src = isImm ? {27'b0, r.zimm} : r.src;
        if (isMret) begin
            illegal = mPriv != privMachine;
        end else begin
            illegal = r.addr[9:8] > mPriv || !rd[32] || (doesWrite && r.addr[11:10] == 2'b11);
        end
        case (r.op)
            opReadSet, opReadSetImm: wdata = rd[31:0] | src;
            opReadClear, opReadClearImm: wdata = rd[31:0] & ~src;
            default: wdata = src;
        endcase
        r.expFlags = illegal ? flagsIllegal : isMret ? flagsXret
                   : doesWrite ? flagsOrdering : flagsNone;
        r.expData = rd[31:0];
        doWr = r.valid && doesWrite && !illegal;
        oldMie = mStMie;
        oldPriv = mPriv;
        pop = 0;
        for (int b = 0; b < 4; b++) pop += r.commit[b];
        if (!mInhibit[0]) mCycle++;
        if (!mInhibit[2]) mInstret += pop;
        if (doWr) begin
            case (r.addr)
                12'h300: begin
                    mStMie = wdata[3];
                    mStMpie = wdata[7];
                    mStMpp = wdata[12:11] == 2'b11 ? privMachine : privUser;
                end
                12'h304: mMie = wdata & 32'h0000_0888;
                12'h305: mMtvec = wdata & ~32'h3;
                12'h306: mCntEn = wdata[2:0] & 3'b101;
                12'h320: mInhibit = wdata[2:0] & 3'b101;
                12'h340: mMscratch = wdata;
                12'h341: mMepc = wdata & ~32'h1;
                12'h342: mMcause = wdata;
                12'h343: mMtval = wdata;
                12'hB00: mCycle[31:0] = wdata;
                12'hB80: mCycle[63:32] = wdata;
                12'hB02: mInstret[31:0] = wdata;
                12'hB82: mInstret[63:32] = wdata;
                default: ;
            endcase
        end
        if (r.valid && isMret && !illegal) begin
            mStMie = mStMpie;
            mPriv = mStMpp;
            mStMpp = privUser;
            mRet = mMepc;
        end
        if (r.trapValid) begin  // wins over a write on the same edge
            mStMpie = oldMie;
            mStMie = 1'b0;
            mStMpp = oldPriv;
            mMepc = r.trapPc & ~32'h1;
            mMcause = {r.trapIsInt, 27'b0, r.trapCause};
            mMtval = r.trapTval;
            mPriv = privMachine;
        end
        mMip = (word_t'(r.irq[0]) << 3) | (word_t'(r.irq[1]) << 7) | (word_t'(r.irq[2]) << 11);
        r.expPriv = mPriv;
        r.expPend = (mPriv == privUser || mStMie) && |(mMie & mMip);
        r.expCause = (mMie[11] && mMip[11]) ? 4'd11 : (mMie[3] && mMip[3]) ? 4'd3
                   : (mMie[7] && mMip[7]) ? 4'd7 : 4'd0;
        r.expRet = mRet;
        r.expVec = mMtvec;
        rows[i] = r;
    endtask

    task automatic buildTable();
        csrAddr_t unknownAddr;
        unknownAddr = csrAddr_t'(12'h7C0);
        // group 6 reset values
        addRow(6, 1, opRead, csrMstatus, 0, 0);
        addRow(6, 1, opRead, csrMepc, 0, 0);
        addRow(6, 1, opRead, csrMie, 0, 0);
        addRow(6, 1, opRead, csrMisa, 0, 0);
        // group 1 back-to-back read-modify-write
        addRow(1, 1, opReadWrite, csrMscratch, nextRand(), 0);
        addRow(1, 1, opReadSet, csrMscratch, nextRand(), 0);
        addRow(1, 1, opReadClear, csrMscratch, nextRand(), 0);
        addRow(1, 1, opReadWriteImm, csrMscratch, nextRand(), 5'h15);
        addRow(1, 1, opReadSetImm, csrMscratch, 0, 5'h0A);
        addRow(1, 1, opReadClearImm, csrMscratch, 0, 5'h03);
        addRow(1, 1, opRead, csrMscratch, 0, 0);
        // group 2 illegal accesses with a drop to user mode via mret
        addRow(2, 1, opReadWrite, csrMarchid, 32'h1234, 0);
        addRow(2, 1, opRead, csrMarchid, 0, 0);
        addRow(2, 1, opRead, unknownAddr, 0, 0);
        addRow(2, 1, opReadWrite, csrMstatus, 32'h88, 0);  // mie, mpie, mpp user
        addRow(2, 1, opMret, csrMstatus, 0, 0);
        addRow(2, 1, opRead, csrInstret, 0, 0);
        addRow(2, 1, opMret, csrMstatus, 0, 0);
        // group 3 trap entry from user and machine mode around an mret
        addRow(3, 0, opRead, csrMstatus, 0, 0);
        setTrap(0, 4'd2, 32'h0000_1235, 32'hdead_0001);
        addRow(3, 1, opRead, csrMstatus, 0, 0);
        addRow(3, 1, opRead, csrMepc, 0, 0);
        addRow(3, 1, opRead, csrMcause, 0, 0);
        addRow(3, 1, opRead, csrMtval, 0, 0);
        addRow(3, 1, opReadWrite, csrMtvec, 32'h0000_8101, 0);
        addRow(3, 1, opRead, csrMtvec, 0, 0);
        addRow(3, 1, opMret, csrMstatus, 0, 0);
        addRow(3, 0, opRead, csrMstatus, 0, 0);
        setTrap(1, 4'd7, 32'h0000_2000, 32'h0);
        addRow(3, 1, opRead, csrMcause, 0, 0);
        addRow(3, 1, opRead, csrMstatus, 0, 0);
        addRow(3, 0, opRead, csrMstatus, 0, 0);
        setTrap(0, 4'd3, 32'h0000_3000, 32'h0000_0044);
        addRow(3, 1, opRead, csrMstatus, 0, 0);
        // group 4 counters
        addRow(4, 1, opReadWrite, csrMcycle, 32'h0000_0100, 0);
        addRow(4, 1, opRead, csrMcycle, 0, 0);
        addRow(4, 1, opReadWrite, csrMcountinhibit, 32'h1, 0);
        addRow(4, 1, opRead, csrMcycle, 0, 0);
        addRow(4, 1, opRead, csrMcycle, 0, 0);
        addRow(4, 1, opRead, csrMinstret, 0, 0);
        setCommit(4'b1011);
        addRow(4, 1, opRead, csrMinstret, 0, 0);
        setCommit(4'b0110);
        addRow(4, 1, opRead, csrMinstret, 0, 0);
        addRow(4, 1, opRead, csrMinstreth, 0, 0);
        // group 5 interrupts
        addRow(5, 1, opReadWrite, csrMie, 32'hffff_ffff, 0);
        addRow(5, 1, opReadWrite, csrMstatus, 32'h1808, 0);
        addRow(5, 1, opRead, csrMip, 0, 0);
        setIrq(3'b110);
        addRow(5, 1, opRead, csrMip, 0, 0);
        setIrq(3'b010);
        addRow(5, 1, opReadClearImm, csrMstatus, 0, 5'h08);
        setIrq(3'b010);
        addRow(5, 1, opRead, csrMip, 0, 0);
        setIrq(3'b010);
    endtask

    task automatic driveRow(input int i);
        uopValid = rows[i].valid;
        uopOp = rows[i].op;
        uopAddr = rows[i].addr;
        uopSrc = rows[i].src;
        uopZimm = rows[i].zimm;
        trapValid = rows[i].trapValid;
        trapIsInterrupt = rows[i].trapIsInt;
        trapCause = rows[i].trapCause;
        trapPc = rows[i].trapPc;
        trapTval = rows[i].trapTval;
        {extIrq, timerIrq, swIrq} = rows[i].irq;
        commitValid = rows[i].commit;
    endtask

    task automatic checkRow(input int i);
        compare("resValid", rows[i].valid, resValid);
        if (rows[i].valid) begin
            compare("resFlags", rows[i].expFlags, resFlags);
            if (rows[i].expFlags inside {flagsNone, flagsOrdering})
                compare("resData", rows[i].expData, resData);
        end
        compare("priv", rows[i].expPriv, priv);
        compare("irqPending", rows[i].expPend, irqPending);
        if (rows[i].expPend)
            compare("irqCause", rows[i].expCause, irqCause);
        compare("retVector", rows[i].expRet, retVector);
        compare("trapVector", rows[i].expVec, trapVector);
    endtask

    initial begin
        groupName[1] = "mscratch read-modify-write";
        groupName[2] = "illegal accesses";
        groupName[3] = "trap entry and mret";
        groupName[4] = "counters";
        groupName[5] = "interrupts";
        groupName[6] = "reset values";
        rst = 1'b1;
        uopValid = 1'b0;
        uopOp = opRead;
        uopAddr = csrMstatus;
        uopSrc = '0;
        uopZimm = '0;
        trapValid = 1'b0;
        trapIsInterrupt = 1'b0;
        trapCause = '0;
        trapPc = '0;
        trapTval = '0;
        commitValid = '0;
        swIrq = 1'b0;
        timerIrq = 1'b0;
        extIrq = 1'b0;
        // model starts from the reset state
        mPriv = privMachine;
        {mStMie, mStMpie} = 2'b00;
        mStMpp = privUser;
        {mMtvec, mMepc, mMcause, mMtval, mMie, mMip, mMscratch, mRet} = '0;
        {mCycle, mInstret} = '0;
        {mCntEn, mInhibit} = '0;
        buildTable();
        for (int i = 0; i < nRows; i++) modelStep(i);
        cycleLimit = 2 * nRows + 50;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        driveRow(0);
        for (int i = 0; i < nRows; i++) begin
            @(posedge clk);
            #1;
            checkRow(i);
            if (i + 1 < nRows) begin
                driveRow(i + 1);
            end else begin
                uopValid = 1'b0;
                trapValid = 1'b0;
                commitValid = '0;
            end
            if (i + 1 == nRows || rows[i+1].group != rows[i].group) begin
                $display("test %0d, %s: %0d mismatches", rows[i].group,
                         groupName[rows[i].group], groupErrors);
                groupErrors = 0;
            end
        end

        $display("%0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
csrPkg.sv
csrReadMux.sv
csrExecute.sv
trapState.sv
perfCounters.sv
csrUnit.sv
tbCsrUnit.sv
